// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/rv_regfile.sv
  - design/rv_hazard_unit.sv
  - design/rv_execute.sv
  - design/rv_mem_stage.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - tb/rv_golden_pkg.sv
      - tb/tb_rv_core.sv

// ==== all.f ====
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_hazard_unit.sv
design/rv_execute.sv
design/rv_mem_stage.sv
design/rv_core.sv
tb/rv_golden_pkg.sv
tb/tb_rv_core.sv

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  wire                   clk,
  input  wire                   rst,
  output rv_pkg::word_t         pc_to_imem,
  input  wire rv_pkg::word_t    insn_from_imem,
  output rv_pkg::word_t         addr_to_dmem,
  input  wire rv_pkg::word_t    load_data_from_dmem,
  output rv_pkg::word_t         store_data_to_dmem,
  output logic [3:0]            store_we_to_dmem,
  output logic                  halt,
  output rv_pkg::word_t         trace_writeback_pc,
  output rv_pkg::word_t         trace_writeback_insn,
  output rv_pkg::cycle_status_e trace_writeback_cycle_status,
  output logic                  trace_rd_we,
  output rv_pkg::reg_addr_t     trace_rd,
  output rv_pkg::word_t         trace_rd_data
);
  import rv_pkg::*;

  word_t f_pc;

  word_t d_pc;
  word_t d_insn;
  cycle_status_e d_status;
  opcode_e d_opcode;
  reg_addr_t d_rs1;
  reg_addr_t d_rs2;
  word_t rf_rs1_data;
  word_t rf_rs2_data;

  word_t x_pc;
  word_t x_insn;
  opcode_e x_opcode;
  cycle_status_e x_status;
  word_t x_rs1_data;
  word_t x_rs2_data;
  word_t x_result;
  word_t x_store_data;
  word_t x_mem_addr;
  logic branch_taken;
  word_t next_pc;

  word_t m_pc;
  word_t m_insn;
  opcode_e m_opcode;
  cycle_status_e m_status;
  word_t m_result;
  word_t m_addr;
  word_t m_store_data;
  word_t m_final;

  word_t w_pc;
  word_t w_insn;
  opcode_e w_opcode;
  cycle_status_e w_status;
  word_t w_result;
  reg_addr_t w_rd;
  logic w_valid;
  logic rf_we;

  fwd_sel_e fwd_rs1;
  fwd_sel_e fwd_rs2;
  logic wd_bypass_rs1;
  logic wd_bypass_rs2;
  logic wm_bypass_store;
  logic load_use_stall;
  logic flush;

  // a branch held by a load-use stall sees stale operands, so it waits
  assign flush = branch_taken && !load_use_stall;

  // fetch
  assign pc_to_imem = f_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      f_pc <= RESET_PC;
    end else if (!load_use_stall) begin
      f_pc <= next_pc;
    end
  end

  // decode
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      d_pc <= '0;
      d_insn <= '0;
      d_status <= rst ? cycle_reset : cycle_taken_branch;
    end else if (!load_use_stall) begin
      d_pc <= f_pc;
      d_insn <= insn_from_imem;
      d_status <= cycle_no_stall;
    end
  end

  assign d_opcode = opcode_e'(d_insn[6:0]);
  assign d_rs1 = d_insn[19:15];
  assign d_rs2 = d_insn[24:20];

  // execute
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      x_pc <= '0;
      x_insn <= '0;
      x_opcode <= opcode_e'(7'd0);
      x_status <= rst ? cycle_reset : cycle_taken_branch;
      x_rs1_data <= '0;
      x_rs2_data <= '0;
    end else if (load_use_stall) begin
      // the writeback producer retires during the stall, keep its value
      if (fwd_rs1 == fwd_from_wb) begin
        x_rs1_data <= w_result;
      end
      if (fwd_rs2 == fwd_from_wb) begin
        x_rs2_data <= w_result;
      end
    end else begin
      x_pc <= d_pc;
      x_insn <= d_insn;
      x_opcode <= d_opcode;
      x_status <= d_status;
      x_rs1_data <= wd_bypass_rs1 ? w_result : rf_rs1_data;
      x_rs2_data <= wd_bypass_rs2 ? w_result : rf_rs2_data;
    end
  end

  // memory, takes the load2use bubble
  always_ff @(posedge clk) begin
    if (rst || load_use_stall) begin
      m_pc <= '0;
      m_insn <= '0;
      m_opcode <= opcode_e'(7'd0);
      m_status <= rst ? cycle_reset : cycle_load2use;
      m_result <= '0;
      m_addr <= '0;
      m_store_data <= '0;
    end else begin
      m_pc <= x_pc;
      m_insn <= x_insn;
      m_opcode <= x_opcode;
      m_status <= x_status;
      m_result <= x_result;
      m_addr <= x_mem_addr;
      m_store_data <= x_store_data;
    end
  end

  // writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc <= '0;
      w_insn <= '0;
      w_opcode <= opcode_e'(7'd0);
      w_status <= cycle_reset;
      w_result <= '0;
    end else begin
      w_pc <= m_pc;
      w_insn <= m_insn;
      w_opcode <= m_opcode;
      w_status <= m_status;
      w_result <= m_final;
    end
  end

  assign w_rd = w_insn[11:7];
  assign w_valid = (w_status == cycle_no_stall);
  assign rf_we = w_valid && writes_rd(w_opcode) && (w_rd != 5'd0);

  // ecall with every other bit clear
  assign halt = w_valid && (w_insn == 32'h0000_0073);

  assign trace_writeback_pc = w_pc;
  assign trace_writeback_insn = w_insn;
  assign trace_writeback_cycle_status = w_status;
  assign trace_rd_we = rf_we;
  assign trace_rd = w_rd;
  assign trace_rd_data = w_result;

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .we       (rf_we),
    .rd       (w_rd),
    .rd_data  (w_result)
  );

  rv_hazard_unit hazard_i (
    .clk             (clk),
    .d_opcode        (d_opcode),
    .d_rs1           (d_rs1),
    .d_rs2           (d_rs2),
    .x_opcode        (x_opcode),
    .x_rs1           (x_insn[19:15]),
    .x_rs2           (x_insn[24:20]),
    .m_opcode        (m_opcode),
    .m_rd            (m_insn[11:7]),
    .m_rs2           (m_insn[24:20]),
    .w_opcode        (w_opcode),
    .w_rd            (w_rd),
    .w_valid         (w_valid),
    .fwd_rs1         (fwd_rs1),
    .fwd_rs2         (fwd_rs2),
    .wd_bypass_rs1   (wd_bypass_rs1),
    .wd_bypass_rs2   (wd_bypass_rs2),
    .wm_bypass_store (wm_bypass_store),
    .load_use_stall  (load_use_stall)
  );

  rv_execute execute_i (
    .pc           (x_pc),
    .insn         (x_insn),
    .opcode       (x_opcode),
    .fwd_rs1      (fwd_rs1),
    .fwd_rs2      (fwd_rs2),
    .rs1_data     (x_rs1_data),
    .rs2_data     (x_rs2_data),
    .m_result     (m_final),
    .w_result     (w_result),
    .fetch_pc     (f_pc),
    .result       (x_result),
    .store_data   (x_store_data),
    .mem_addr     (x_mem_addr),
    .branch_taken (branch_taken),
    .next_pc      (next_pc)
  );

  rv_mem_stage mem_stage_i (
    .clk             (clk),
    .opcode          (m_opcode),
    .funct3          (m_insn[14:12]),
    .addr            (m_addr),
    .store_data      (m_store_data),
    .wm_bypass_store (wm_bypass_store),
    .w_result        (w_result),
    .alu_result      (m_result),
    .load_data       (load_data_from_dmem),
    .dmem_addr       (addr_to_dmem),
    .dmem_wdata      (store_data_to_dmem),
    .dmem_we         (store_we_to_dmem),
    .result          (m_final)
  );

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire rv_pkg::word_t    pc,
  input  wire rv_pkg::word_t    insn,
  input  wire rv_pkg::opcode_e  opcode,
  input  wire rv_pkg::fwd_sel_e fwd_rs1,
  input  wire rv_pkg::fwd_sel_e fwd_rs2,
  input  wire rv_pkg::word_t    rs1_data,
  input  wire rv_pkg::word_t    rs2_data,
  input  wire rv_pkg::word_t    m_result,
  input  wire rv_pkg::word_t    w_result,
  input  wire rv_pkg::word_t    fetch_pc,
  output rv_pkg::word_t         result,
  output rv_pkg::word_t         store_data,
  output rv_pkg::word_t         mem_addr,
  output logic                  branch_taken,
  output rv_pkg::word_t         next_pc
);
  import rv_pkg::*;

  logic [2:0] funct3;
  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_out;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t target;
  logic [4:0] shamt;
  logic cond;

  function automatic word_t pick(fwd_sel_e sel, word_t rf_val, word_t m_val, word_t w_val);
    case (sel)
      fwd_from_mem: return m_val;
      fwd_from_wb:  return w_val;
      default:      return rf_val;
    endcase
  endfunction

  assign funct3 = insn[14:12];
  assign op_a = pick(fwd_rs1, rs1_data, m_result, w_result);
  assign op_b = pick(fwd_rs2, rs2_data, m_result, w_result);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  assign alu_b = (opcode == op_reg_reg) ? op_b : imm_i;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (funct3)
      3'b000: begin
        // insn[30] is an immediate bit for addi, so only reg-reg subtracts
        if ((opcode == op_reg_reg) && insn[30]) begin
          alu_out = op_a - alu_b;
        end else begin
          alu_out = op_a + alu_b;
        end
      end
      3'b001: alu_out = op_a << shamt;
      3'b010: alu_out = ($signed(op_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
      3'b011: alu_out = (op_a < alu_b) ? 32'd1 : 32'd0;
      3'b100: alu_out = op_a ^ alu_b;
      3'b101: alu_out = insn[30] ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
      3'b110: alu_out = op_a | alu_b;
      default: alu_out = op_a & alu_b;
    endcase
  end

  always_comb begin
    case (opcode)
      op_lui:          result = imm_u;
      op_auipc:        result = pc + imm_u;
      op_jal, op_jalr: result = pc + 32'd4;
      default:         result = alu_out;
    endcase
  end

  // branch condition
  always_comb begin
    case (funct3)
      3'b000: cond = (op_a == op_b);
      3'b001: cond = (op_a != op_b);
      3'b100: cond = ($signed(op_a) < $signed(op_b));
      3'b101: cond = ($signed(op_a) >= $signed(op_b));
      3'b110: cond = (op_a < op_b);
      3'b111: cond = (op_a >= op_b);
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jal:  target = pc + imm_j;
      op_jalr: target = (op_a + imm_i) & ~32'd1;
      default: target = pc + imm_b;
    endcase
  end

  assign branch_taken = ((opcode == op_branch) && cond) ||
                        (opcode == op_jal) || (opcode == op_jalr);
  assign next_pc = branch_taken ? target : fetch_pc + 32'd4;

  assign mem_addr = op_a + ((opcode == op_store) ? imm_s : imm_i);
  assign store_data = op_b;

endmodule

`default_nettype wire

// ==== design/rv_hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
  input  wire                    clk,
  input  wire rv_pkg::opcode_e   d_opcode,
  input  wire rv_pkg::reg_addr_t d_rs1,
  input  wire rv_pkg::reg_addr_t d_rs2,
  input  wire rv_pkg::opcode_e   x_opcode,
  input  wire rv_pkg::reg_addr_t x_rs1,
  input  wire rv_pkg::reg_addr_t x_rs2,
  input  wire rv_pkg::opcode_e   m_opcode,
  input  wire rv_pkg::reg_addr_t m_rd,
  input  wire rv_pkg::reg_addr_t m_rs2,
  input  wire rv_pkg::opcode_e   w_opcode,
  input  wire rv_pkg::reg_addr_t w_rd,
  input  wire                    w_valid,
  output rv_pkg::fwd_sel_e       fwd_rs1,
  output rv_pkg::fwd_sel_e       fwd_rs2,
  output logic                   wd_bypass_rs1,
  output logic                   wd_bypass_rs2,
  output logic                   wm_bypass_store,
  output logic                   load_use_stall
);
  import rv_pkg::*;

  logic m_load_hit;
  logic m_fwd_ok;
  logic w_fwd_ok;

  // a load in memory has no data yet, so it never feeds execute directly
  assign m_fwd_ok = writes_rd(m_opcode) && (m_opcode != op_load) && (m_rd != 5'd0);
  assign w_fwd_ok = w_valid && writes_rd(w_opcode) && (w_rd != 5'd0);

  function automatic fwd_sel_e pick_src(logic used, reg_addr_t src, logic m_ok,
                                        reg_addr_t m_dst, logic w_ok, reg_addr_t w_dst);
    if (used && m_ok && (m_dst == src)) begin
      return fwd_from_mem;
    end else if (used && w_ok && (w_dst == src)) begin
      return fwd_from_wb;
    end
    return fwd_regfile_val;
  endfunction

  assign fwd_rs1 = pick_src(reads_rs1(x_opcode), x_rs1, m_fwd_ok, m_rd, w_fwd_ok, w_rd);
  assign fwd_rs2 = pick_src(reads_rs2(x_opcode), x_rs2, m_fwd_ok, m_rd, w_fwd_ok, w_rd);

  // regfile read and write in the same cycle
  assign wd_bypass_rs1 = reads_rs1(d_opcode) && w_fwd_ok && (w_rd == d_rs1);
  assign wd_bypass_rs2 = reads_rs2(d_opcode) && w_fwd_ok && (w_rd == d_rs2);

  assign wm_bypass_store = (m_opcode == op_store) && w_fwd_ok && (w_rd == m_rs2);

  assign m_load_hit = (m_opcode == op_load) && (m_rd != 5'd0);
  assign load_use_stall = m_load_hit &&
                          ((reads_rs1(x_opcode) && (x_rs1 == m_rd)) ||
                           (reads_rs2(x_opcode) && (x_rs2 == m_rd)));

  assert property (@(posedge clk) load_use_stall |-> m_opcode == op_load)
    else $error("load-use stall without a load in memory");

  assert property (@(posedge clk) load_use_stall |-> fwd_rs1 != fwd_from_mem)
    else $error("rs1 bypassed from memory during a load-use stall");

  // the bubble moves the load on, so a stall never lasts two cycles
  assert property (@(posedge clk) load_use_stall |=> !load_use_stall)
    else $error("load-use stall held for more than one cycle");

endmodule

`default_nettype wire

// ==== design/rv_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mem_stage (
  input  wire                   clk,
  input  wire rv_pkg::opcode_e  opcode,
  input  wire [2:0]             funct3,
  input  wire rv_pkg::word_t    addr,
  input  wire rv_pkg::word_t    store_data,
  input  wire                   wm_bypass_store,
  input  wire rv_pkg::word_t    w_result,
  input  wire rv_pkg::word_t    alu_result,
  input  wire rv_pkg::word_t    load_data,
  output rv_pkg::word_t         dmem_addr,
  output rv_pkg::word_t         dmem_wdata,
  output logic [3:0]            dmem_we,
  output rv_pkg::word_t         result
);
  import rv_pkg::*;

  logic [1:0] offset;
  logic [4:0] lane_shift;
  word_t wdata_src;
  word_t load_shifted;
  word_t load_val;

  assign offset = addr[1:0];
  assign lane_shift = {offset, 3'b000};
  assign dmem_addr = {addr[XLEN-1:2], 2'b00};

  // store data may come from the instruction now retiring
  assign wdata_src = wm_bypass_store ? w_result : store_data;

  always_comb begin
    dmem_wdata = '0;
    dmem_we = 4'b0000;
    if (opcode == op_store) begin
      case (funct3[1:0])
        2'b00: begin
          dmem_wdata = {24'b0, wdata_src[7:0]} << lane_shift;
          dmem_we = 4'b0001 << offset;
        end
        2'b01: begin
          dmem_wdata = {16'b0, wdata_src[15:0]} << lane_shift;
          dmem_we = offset[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          dmem_wdata = wdata_src;
          dmem_we = 4'b1111;
        end
      endcase
    end
  end

  // addressed byte or halfword moved down to bit 0
  assign load_shifted = load_data >> lane_shift;

  always_comb begin
    case (funct3)
      3'b000: load_val = {{24{load_shifted[7]}}, load_shifted[7:0]};
      3'b001: load_val = {{16{load_shifted[15]}}, load_shifted[15:0]};
      3'b100: load_val = {24'b0, load_shifted[7:0]};
      3'b101: load_val = {16'b0, load_shifted[15:0]};
      default: load_val = load_data;
    endcase
  end

  assign result = (opcode == op_load) ? load_val : alu_result;

  assert property (@(posedge clk)
    ((opcode == op_load) || (opcode == op_store)) |->
      ((funct3[1:0] == 2'b00) ||
       ((funct3[1:0] == 2'b01) && !addr[0]) ||
       (addr[1:0] == 2'b00)))
    else $error("misaligned data access at %h", addr);

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_branch  = 7'b1100011,
    op_jalr    = 7'b1100111,
    op_jal     = 7'b1101111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_environ = 7'b1110011,
    op_auipc   = 7'b0010111,
    op_lui     = 7'b0110111
  } opcode_e;

  // one-hot writeback status, bits 4 and 5 stay spare
  typedef enum logic [5:0] {
    cycle_invalid      = 6'd0,
    cycle_reset        = 6'd1,
    cycle_no_stall     = 6'd2,
    cycle_taken_branch = 6'd4,
    cycle_load2use     = 6'd8
  } cycle_status_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    fwd_regfile_val,
    fwd_from_mem,
    fwd_from_wb
  } fwd_sel_e;

  function automatic logic writes_rd(opcode_e op);
    case (op)
      op_load, op_jalr, op_jal, op_reg_imm, op_reg_reg, op_auipc, op_lui: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic reads_rs1(opcode_e op);
    case (op)
      op_load, op_store, op_branch, op_jalr, op_reg_imm, op_reg_reg: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic reads_rs2(opcode_e op);
    case (op)
      op_store, op_branch, op_reg_reg: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                clk,
  input  wire                rst,
  input  wire rv_pkg::reg_addr_t rs1,
  input  wire rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t      rs1_data,
  output rv_pkg::word_t      rs2_data,
  input  wire                we,
  input  wire rv_pkg::reg_addr_t rd,
  input  wire rv_pkg::word_t rd_data
);
  import rv_pkg::*;

  // x1..x31, x0 is hardwired
  word_t regs [1:31];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= rd_data;
    end
  end

  // writeback must stay quiet while the pipeline is being reset
  assert property (@(posedge clk) rst |-> !we)
    else $error("regfile write enabled during reset");

endmodule

`default_nettype wire

// ==== tb/rv_golden_pkg.sv ====
`default_nettype none

package rv_golden_pkg;

  localparam int PROG_LEN = 200;
  localparam int MEM_WORDS = 512;
  localparam logic [31:0] NOP = 32'h0000_0013;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic [31:0] lfsr_state = 32'h4463;
  logic [31:0] prog [PROG_LEN];

  // expected retire stream, one entry per instruction
  logic [31:0] exp_pc [$];
  logic [31:0] exp_insn [$];
  int exp_taken [$];
  int exp_stall [$];
  logic [4:0] exp_rd [$];
  logic [31:0] exp_rd_data [$];
  logic [31:0] exp_st_addr [$];
  logic [3:0] exp_st_we [$];
  logic [31:0] exp_st_data [$];

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // n fresh bits, one lfsr step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // program, then nops up to the data region, then a pattern
  function automatic logic [31:0] init_word(int idx);
    logic [31:0] a;
    a = idx * 4;
    if (idx < PROG_LEN) begin
      return prog[idx];
    end
    if (a < 32'h400) begin
      return NOP;
    end
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  // data region 0x400..0x7ff, reachable off x0
  function automatic logic [31:0] data_addr(logic [1:0] size);
    logic [31:0] a;
    a = 32'h400 + (rand_bits(8) << 2);
    if (size == 2'd0) begin
      a = a + rand_bits(2);
    end else if (size == 2'd1) begin
      a = a + (rand_bits(1) << 1);
    end
    return a;
  endfunction

  task automatic build_program();
    int i;
    int sel;
    int k;
    logic [31:0] a;
    logic [31:0] sub;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    i = 0;
    while (i < PROG_LEN - 1) begin
      sel = rand_bits(4);
      rd = rand_bits(3);
      rs1 = rand_bits(3);
      rs2 = rand_bits(3);
      f3 = rand_bits(3);
      k = 1 + rand_bits(2);
      if (i + k > PROG_LEN - 1) begin
        k = PROG_LEN - 1 - i;
      end
      if (sel < 6) begin
        sub = ((f3 == 3'd0) || (f3 == 3'd5)) ? rand_bits(1) : 32'd0;
        prog[i] = {1'b0, sub[0], 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      end else if (sel < 9) begin
        if (f3 == 3'd1) begin
          imm = {7'b0, rs2};
        end else if (f3 == 3'd5) begin
          imm = {1'b0, rand_bits(1) == 1, 5'b0, rs2};
        end else begin
          imm = rand_bits(12);
        end
        prog[i] = {imm, rs1, f3, rd, 7'b0010011};
      end else if (sel == 9) begin
        a = rand_bits(20);
        prog[i] = {a[19:0], rd, rs1[0] ? 7'b0110111 : 7'b0010111};
      end else if (sel == 10) begin
        case (f3 % 5)
          0: f3 = 3'd0;
          1: f3 = 3'd1;
          2: f3 = 3'd2;
          3: f3 = 3'd4;
          default: f3 = 3'd5;
        endcase
        a = data_addr(f3[1:0]);
        prog[i] = {a[11:0], 5'd0, f3, rd, 7'b0000011};
      end else if (sel == 11) begin
        f3 = f3 % 3;
        a = data_addr(f3[1:0]);
        prog[i] = {a[11:5], rs2, 5'd0, f3, a[4:0], 7'b0100011};
      end else if (sel == 12) begin
        // funct3 2 and 3 are not branches
        if (f3 == 3'd2 || f3 == 3'd3) begin
          f3 = f3 - 3'd2;
        end
        boff = k * 4;
        prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      end else if (sel == 13) begin
        joff = k * 4;
        prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      end else if (i < PROG_LEN - 2) begin
        // load, then an add that needs its rd at once
        if (rd == 5'd0) begin
          rd = 5'd1;
        end
        a = data_addr(2'd2);
        prog[i] = {a[11:0], 5'd0, 3'd2, rd, 7'b0000011};
        i++;
        prog[i] = {7'b0, rs2, rd, 3'd0, rs1, 7'b0110011};
      end else begin
        prog[i] = NOP;
      end
      i++;
    end
    prog[PROG_LEN-1] = ECALL;
  endtask

  function automatic logic needs_rs1(logic [6:0] op);
    return op inside {7'b0000011, 7'b0100011, 7'b1100011, 7'b1100111,
                      7'b0010011, 7'b0110011};
  endfunction

  function automatic logic needs_rs2(logic [6:0] op);
    return op inside {7'b0100011, 7'b1100011, 7'b0110011};
  endfunction

  function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                      logic [31:0] b);
    logic [31:0] sra;
    sra = $signed(a) >>> b[4:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? sra : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // architectural run of the program, fills the expected queues
  task automatic run_model();
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] ld;
    logic [31:0] nxt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] wdata;
    logic [3:0] we;
    logic [6:0] op;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] last_load_rd;
    logic taken;
    logic writes;
    logic last_taken;
    int steps;
    foreach (mem[j]) begin
      mem[j] = init_word(j);
    end
    foreach (x[j]) begin
      x[j] = '0;
    end
    pc = 32'h0;
    last_load_rd = '0;
    last_taken = 1'b0;
    steps = 0;
    while (steps < 1000) begin
      insn = mem[pc[10:2]];
      op = insn[6:0];
      f3 = insn[14:12];
      rd = insn[11:7];
      rs1 = insn[19:15];
      rs2 = insn[24:20];
      a = x[rs1];
      b = x[rs2];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      exp_pc.push_back(pc);
      exp_insn.push_back(insn);
      exp_taken.push_back(last_taken ? 2 : 0);
      exp_stall.push_back(((last_load_rd != 0) &&
                           ((needs_rs1(op) && rs1 == last_load_rd) ||
                            (needs_rs2(op) && rs2 == last_load_rd))) ? 1 : 0);
      if (insn == ECALL) begin
        break;
      end
      nxt = pc + 4;
      taken = 1'b0;
      writes = 1'b1;
      res = '0;
      case (op)
        7'b0110111: res = {insn[31:12], 12'b0};
        7'b0010111: res = pc + {insn[31:12], 12'b0};
        7'b1101111: begin
          res = pc + 4;
          nxt = pc + imm_j;
          taken = 1'b1;
        end
        7'b1100111: begin
          res = pc + 4;
          nxt = (a + imm_i) & ~32'd1;
          taken = 1'b1;
        end
        7'b1100011: begin
          writes = 1'b0;
          taken = branch_cond(f3, a, b);
          if (taken) begin
            nxt = pc + imm_b;
          end
        end
        7'b0000011: begin
          addr = a + imm_i;
          ld = mem[addr[10:2]] >> {addr[1:0], 3'b000};
          case (f3)
            3'd0: res = {{24{ld[7]}}, ld[7:0]};
            3'd1: res = {{16{ld[15]}}, ld[15:0]};
            3'd4: res = {24'b0, ld[7:0]};
            3'd5: res = {16'b0, ld[15:0]};
            default: res = ld;
          endcase
        end
        7'b0100011: begin
          writes = 1'b0;
          addr = a + imm_s;
          case (f3)
            3'd0: begin
              we = 4'b0001 << addr[1:0];
              wdata = {24'b0, b[7:0]} << {addr[1:0], 3'b000};
            end
            3'd1: begin
              we = 4'b0011 << addr[1:0];
              wdata = {16'b0, b[15:0]} << {addr[1:0], 3'b000};
            end
            default: begin
              we = 4'b1111;
              wdata = b;
            end
          endcase
          for (int n = 0; n < 4; n++) begin
            if (we[n]) begin
              mem[addr[10:2]][8*n +: 8] = wdata[8*n +: 8];
            end
          end
          exp_st_addr.push_back({addr[31:2], 2'b00});
          exp_st_we.push_back(we);
          exp_st_data.push_back(wdata);
        end
        7'b0010011: res = alu(f3, (f3 == 3'd5) && insn[30], a, imm_i);
        7'b0110011: res = alu(f3, insn[30], a, b);
        default: writes = 1'b0;
      endcase
      if (writes && rd != 5'd0) begin
        x[rd] = res;
        exp_rd.push_back(rd);
        exp_rd_data.push_back(res);
      end
      last_taken = taken;
      last_load_rd = (op == 7'b0000011) ? rd : 5'd0;
      pc = nxt;
      steps++;
    end
  endtask

endpackage

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;
  import rv_golden_pkg::*;

  localparam int MAX_CYCLES = 16 + 3 * PROG_LEN + 20;

  logic clk;
  logic rst;
  logic [31:0] insn_from_imem;
  logic [31:0] load_data_from_dmem;
  logic [31:0] pc_to_imem;
  logic [31:0] addr_to_dmem;
  logic [31:0] store_data_to_dmem;
  logic [3:0] store_we_to_dmem;
  logic halt;
  logic [31:0] trace_pc;
  logic [31:0] trace_insn;
  logic [5:0] trace_status;
  logic trace_rd_we;
  logic [4:0] trace_rd;
  logic [31:0] trace_rd_data;

  logic [31:0] mem [MEM_WORDS];
  int cycles;
  int retired;
  int rd_idx;
  int st_idx;
  int taken_seen;
  int stall_seen;
  logic started;
  logic done;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) dut_i (
    .clk                          (clk),
    .rst                          (rst),
    .pc_to_imem                   (pc_to_imem),
    .insn_from_imem               (insn_from_imem),
    .addr_to_dmem                 (addr_to_dmem),
    .load_data_from_dmem          (load_data_from_dmem),
    .store_data_to_dmem           (store_data_to_dmem),
    .store_we_to_dmem             (store_we_to_dmem),
    .halt                         (halt),
    .trace_writeback_pc           (trace_pc),
    .trace_writeback_insn         (trace_insn),
    .trace_writeback_cycle_status (trace_status),
    .trace_rd_we                  (trace_rd_we),
    .trace_rd                     (trace_rd),
    .trace_rd_data                (trace_rd_data)
  );

  always #2 clk = ~clk;

  // unified memory, answers on the falling edge, read before write
  always @(negedge clk) begin
    insn_from_imem <= mem[pc_to_imem[10:2]];
    load_data_from_dmem <= mem[addr_to_dmem[10:2]];
    for (int n = 0; n < 4; n++) begin
      if (store_we_to_dmem[n]) begin
        mem[addr_to_dmem[10:2]][8*n +: 8] <= store_data_to_dmem[8*n +: 8];
      end
    end
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, want);
      fail_run("value mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      fail_run($sformatf("halt never came within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic retire_one();
    if (retired >= exp_pc.size()) begin
      fail_run("more instructions retired than the model executed");
    end
    compare_value("trace_writeback_pc", trace_pc, exp_pc[retired]);
    compare_value("trace_writeback_insn", trace_insn, exp_insn[retired]);
    compare_value("taken_branch bubbles", taken_seen, exp_taken[retired]);
    compare_value("load2use bubbles", stall_seen, exp_stall[retired]);
    taken_seen = 0;
    stall_seen = 0;
    retired++;
  endtask

  task automatic watch_cycle();
    logic halt_due;
    halt_due = 1'b0;
    if (trace_status == cycle_reset) begin
      if (started) begin
        fail_run("reset status in writeback after the pipeline started");
      end
    end else begin
      started = 1'b1;
      case (trace_status)
        cycle_taken_branch: taken_seen++;
        cycle_load2use: stall_seen++;
        cycle_no_stall: begin
          retire_one();
          // the model's last instruction is the ecall
          halt_due = (retired == exp_pc.size());
        end
        default: fail_run("invalid cycle status in writeback");
      endcase
    end
    if (trace_rd_we) begin
      if (rd_idx >= exp_rd.size()) begin
        fail_run("register write that the model never made");
      end
      compare_value("trace_rd", trace_rd, exp_rd[rd_idx]);
      compare_value("trace_rd_data", trace_rd_data, exp_rd_data[rd_idx]);
      rd_idx++;
    end
    if (store_we_to_dmem != 4'b0000) begin
      if (st_idx >= exp_st_addr.size()) begin
        fail_run("store that the model never made");
      end
      compare_value("addr_to_dmem", addr_to_dmem, exp_st_addr[st_idx]);
      compare_value("store_we_to_dmem", store_we_to_dmem, exp_st_we[st_idx]);
      compare_value("store_data_to_dmem", store_data_to_dmem, exp_st_data[st_idx]);
      st_idx++;
    end
    compare_value("halt", halt, halt_due);
    if (halt) begin
      compare_value("register write count", rd_idx, exp_rd.size());
      compare_value("store count", st_idx, exp_st_addr.size());
      done = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn_from_imem = '0;
    load_data_from_dmem = '0;
    cycles = 0;
    retired = 0;
    rd_idx = 0;
    st_idx = 0;
    taken_seen = 0;
    stall_seen = 0;
    started = 1'b0;
    done = 1'b0;
    build_program();
    run_model();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = init_word(i);
    end
    repeat (16) begin
      @(negedge clk);
      compare_value("trace_writeback_cycle_status", trace_status, cycle_reset);
      compare_value("trace_writeback_pc", trace_pc, 32'h0);
      compare_value("trace_writeback_insn", trace_insn, 32'h0);
      compare_value("trace_rd_we", trace_rd_we, 1'b0);
      compare_value("halt", halt, 1'b0);
    end
    rst = 1'b0;
    // first cycle out of reset still shows reset
    @(negedge clk);
    compare_value("trace_writeback_cycle_status", trace_status, cycle_reset);
    compare_value("trace_writeback_pc", trace_pc, 32'h0);
    compare_value("trace_writeback_insn", trace_insn, 32'h0);
    compare_value("store_we_to_dmem", store_we_to_dmem, 4'b0000);
    compare_value("trace_rd_we", trace_rd_we, 1'b0);
    compare_value("halt", halt, 1'b0);
    while (!done) begin
      @(negedge clk);
      watch_cycle();
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
